// File: m68k_cache_config.svh
// cache geometry and timing
`ifndef M68K_CACHE_CONFIG_SVH
`define M68K_CACHE_CONFIG_SVH

// organisation of the cache
`define CACHE_WAYS   4      // ways per set
`define CACHE_SETS   128    // sets, indexed by address bits 10..4
`define LINE_WORDS   8      // 16 bit words per line

// bus widths
`define TAG_W        21     // address bits 31..11
`define ADDR_W       32     // 68k address bus
`define DATA_W       16     // 68k data bus

// dram timing as seen by the controller
`define CAS_LATENCY  2      // clocks from cas to first burst word

`endif

// File: cpuBusPkg.sv
// cpu and dram bus types
`include "m68k_cache_config.svh"

package cpuBusPkg;

	// request from the 68k, all strobes straight off the cpu pins
	typedef struct packed {
		logic [`ADDR_W-1:0] address;
		logic [`DATA_W-1:0] writeData;
		logic               udsL;       // upper byte strobe, bits 15..8
		logic               ldsL;       // lower byte strobe, bits 7..0
		logic               weL;        // low for a write
		logic               asL;        // address strobe
		logic               dramSelect; // high when the dram region is decoded
	} cpuReq_t;

	// answer back to the 68k
	typedef struct packed {
		logic [`DATA_W-1:0] readData;
		logic               dtackL;
	} cpuResp_t;

	// command into the dram controller, everything active low
	typedef struct packed {
		logic [`ADDR_W-1:0] address;
		logic [`DATA_W-1:0] writeData;
		logic               udsL;
		logic               ldsL;
		logic               weL;
		logic               asL;
		logic               selectL;    // kicks off a dram access
	} dramCmd_t;

	// status out of the dram controller
	typedef struct packed {
		logic [`DATA_W-1:0] readData;   // burst data during a fill
		logic               casL;
		logic               rasL;       // high with cas low means a read, not refresh
		logic               dtackL;
	} dramStat_t;

endpackage

// File: cachePkg.sv
// cache types and controller states
`include "m68k_cache_config.svh"

package cachePkg;

	// controller states
	typedef enum logic [3:0] {
		resetClr      = 4'd0,  // arm the set counter
		invalidate    = 4'd1,  // walk all sets clearing tags, valids, lru
		idle          = 4'd2,
		checkHit      = 4'd3,  // compare tags for a read
		waitCacheRead = 4'd4,  // hit, hold dtack till cpu lets go
		allocLine     = 4'd5,  // write tag and valid, wait for dram cas
		casWait       = 4'd6,
		burstFill     = 4'd7,  // one word per clock into the fill way
		endFill       = 4'd8,
		writeThrough  = 4'd9
	} cacheState_e;

	typedef logic [$clog2(`CACHE_WAYS)-1:0] wayIdx_t;
	typedef logic [`CACHE_WAYS-1:0]         wayMask_t;   // one bit per way
	typedef logic [`TAG_W-1:0]              tag_t;
	typedef logic [$clog2(`CACHE_SETS)-1:0] setIdx_t;
	typedef logic [$clog2(`LINE_WORDS)-1:0] wordIdx_t;
	typedef logic [`CACHE_WAYS-2:0]         lruBits_t;   // tree bits b2 b1 b0

	// one write into the store, masks pick the ways
	typedef struct packed {
		setIdx_t  set;
		tag_t     tag;
		wordIdx_t word;
		logic     valid;    // value for the valid bit
		wayMask_t tagWe;
		wayMask_t validWe;
		wayMask_t dataWe;
	} storeWr_t;

	// what a lookup returns
	typedef struct packed {
		wayMask_t           validHit; // valid and tag match
		wayMask_t           valid;
		logic [`DATA_W-1:0] readWord; // word from the lowest hit way
	} lookup_t;

endpackage

// File: cacheStore.sv
// tag valid and data arrays
`timescale 1ns/1ps
`include "m68k_cache_config.svh"

module cacheStore (
	input  logic                Clock,
	input  logic                Reset_L,
	input  cachePkg::storeWr_t  wr,
	input  logic [`DATA_W-1:0]  fillData,     // burst word from dram
	input  cachePkg::setIdx_t   lookupSet,
	input  cachePkg::tag_t      lookupTag,
	input  cachePkg::wordIdx_t  lookupWord,
	output cachePkg::lookup_t   result
);

	// per way storage, data indexed by {set, word}
	cachePkg::tag_t          tagMem  [`CACHE_WAYS][`CACHE_SETS];
	logic [`DATA_W-1:0]      dataMem [`CACHE_WAYS][`CACHE_SETS*`LINE_WORDS];
	logic [`CACHE_SETS-1:0]  validMem [`CACHE_WAYS];

	cachePkg::wayMask_t      validNow;    // valid bits of the looked up set
	cachePkg::wayMask_t      hitNow;      // valid and matching tag
	cachePkg::wayIdx_t       readWay;     // lowest hitting way

	//////////////////////////////////////////////////////////////////////
	// writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock) begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (wr.tagWe[w])
				tagMem[w][wr.set] <= wr.tag;
			if (wr.dataWe[w])
				dataMem[w][{wr.set, wr.word}] <= fillData;   // one word per clock in a fill
		end
	end

	// valid bits also swept by the invalidate walk after reset
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			validMem <= '{default: '0};
		end else begin
			for (int w = 0; w < `CACHE_WAYS; w++)
				if (wr.validWe[w])
					validMem[w][wr.set] <= wr.valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// lookup, all four tags at once
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		readWay = '0;
		for (int w = `CACHE_WAYS-1; w >= 0; w--) begin   // walk down so way 0 wins
			validNow[w] = validMem[w][lookupSet];
			hitNow[w]   = validMem[w][lookupSet] && (tagMem[w][lookupSet] == lookupTag);
			if (validMem[w][lookupSet] && (tagMem[w][lookupSet] == lookupTag))
				readWay = cachePkg::wayIdx_t'(w);
		end
	end

	assign result.validHit = hitNow;
	assign result.valid    = validNow;
	assign result.readWord = dataMem[readWay][{lookupSet, lookupWord}]; // async read

endmodule

// File: lruPolicy.sv
// pseudo lru tree per set
`timescale 1ns/1ps
`include "m68k_cache_config.svh"

module lruPolicy (
	input  logic               Clock,
	input  logic               Reset_L,
	input  cachePkg::setIdx_t  set,
	input  logic               clear,      // zero the bits of this set
	input  logic               touch,      // mark touchWay most recent
	input  cachePkg::wayIdx_t  touchWay,
	output cachePkg::wayIdx_t  victim
);

	cachePkg::lruBits_t lruMem [`CACHE_SETS];
	cachePkg::lruBits_t curBits;     // bits of the addressed set
	cachePkg::lruBits_t newBits;     // after a touch

	assign curBits = lruMem[set];

	// b0 picks the half, b1 or b2 picks the way inside it
	always_comb begin
		if (!curBits[0])
			victim = curBits[1] ? 2'd1 : 2'd0;
		else
			victim = curBits[2] ? 2'd3 : 2'd2;
	end

	// point the tree away from the touched way
	always_comb begin
		newBits = curBits;
		case (touchWay)
			2'd0: begin
				newBits[0] = 1'b1;
				newBits[1] = 1'b1;
			end
			2'd1: begin
				newBits[0] = 1'b1;
				newBits[1] = 1'b0;
			end
			2'd2: begin
				newBits[0] = 1'b0;
				newBits[2] = 1'b1;
			end
			default: begin    // way 3
				newBits[0] = 1'b0;
				newBits[2] = 1'b0;
			end
		endcase
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L)
			lruMem <= '{default: '0};
		else if (clear)
			lruMem[set] <= '0;       // invalidate walk
		else if (touch)
			lruMem[set] <= newBits;
	end

endmodule

// File: cacheController.sv
// cache controller state machine
`timescale 1ns/1ps
`include "m68k_cache_config.svh"

module cacheController (
	input  logic                  Clock,
	input  logic                  Reset_L,
	input  cpuBusPkg::cpuReq_t    cpuReq,
	input  cpuBusPkg::dramStat_t  dramStat,
	input  cachePkg::lookup_t     result,
	input  cachePkg::wayIdx_t     victim,
	output cpuBusPkg::cpuResp_t   cpuResp,
	output cpuBusPkg::dramCmd_t   dramCmd,
	output cachePkg::storeWr_t    wr,
	output cachePkg::setIdx_t     lookupSet,
	output cachePkg::wordIdx_t    lookupWord,
	output logic                  lruClear,
	output logic                  lruTouch,
	output cachePkg::wayIdx_t     lruTouchWay
);

	cachePkg::cacheState_e state, nextState;
	cachePkg::setIdx_t     cnt, cntNext;       // set walk, cas wait and burst word
	cachePkg::wayIdx_t     fillWay;            // way picked on a miss
	cachePkg::wayIdx_t     fillWayNext;
	logic                  loadFill;
	cachePkg::wayMask_t    fillMask;           // one hot of fillWay
	cachePkg::wayIdx_t     hitWay;
	cachePkg::wayIdx_t     freeWay;            // lowest invalid way
	logic                  anyHit;
	logic                  cycleActive;        // cpu still holds the bus cycle
	logic                  lineRead;           // dram sees a line aligned read

	// lowest set bit of a way mask
	function automatic cachePkg::wayIdx_t lowestSet(input cachePkg::wayMask_t mask);
		cachePkg::wayIdx_t idx;
		idx = '0;
		for (int w = `CACHE_WAYS-1; w >= 0; w--)
			if (mask[w])
				idx = cachePkg::wayIdx_t'(w);
		return idx;
	endfunction

	assign cycleActive = !cpuReq.asL && cpuReq.dramSelect;
	assign anyHit      = |result.validHit;
	assign hitWay      = lowestSet(result.validHit);
	assign freeWay     = lowestSet(~result.valid);
	assign fillWayNext = (&result.valid) ? victim : freeWay;   // empty ways first
	assign fillMask    = cachePkg::wayMask_t'(1) << fillWay;

	//////////////////////////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= cachePkg::resetClr;
			cnt   <= '0;
		end else begin
			state <= nextState;
			cnt   <= cntNext;
		end
	end

	always_ff @(posedge Clock) begin
		if (loadFill)
			fillWay <= fillWayNext;   // held for the whole fill
	end

	//////////////////////////////////////////////////////////////////////
	// next state and outputs
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState   = state;
		cntNext     = cnt;
		loadFill    = 1'b0;
		lineRead    = 1'b0;
		lookupSet   = cpuReq.address[10:4];
		lookupWord  = cpuReq.address[3:1];
		wr          = '0;
		wr.tag      = cpuReq.address[31:11];
		lruClear    = 1'b0;
		lruTouch    = 1'b0;
		lruTouchWay = hitWay;

		// dram follows the cpu unless a state says otherwise
		dramCmd.address   = cpuReq.address;
		dramCmd.writeData = cpuReq.writeData;
		dramCmd.udsL      = cpuReq.udsL;
		dramCmd.ldsL      = cpuReq.ldsL;
		dramCmd.weL       = cpuReq.weL;
		dramCmd.asL       = cpuReq.asL;
		dramCmd.selectL   = 1'b1;

		cpuResp.readData  = result.readWord;
		cpuResp.dtackL    = 1'b1;

		case (state)
			cachePkg::resetClr: begin
				cntNext   = '0;
				nextState = cachePkg::invalidate;
			end

			cachePkg::invalidate: begin   // one set per clock
				lookupSet  = cnt;
				wr.tag     = '0;
				wr.valid   = 1'b0;
				wr.tagWe   = '1;
				wr.validWe = '1;
				lruClear   = 1'b1;
				cntNext    = cnt + 1'b1;  // wraps back to 0 on the last set
				if (cnt == cachePkg::setIdx_t'(`CACHE_SETS-1))
					nextState = cachePkg::idle;
			end

			cachePkg::idle: begin
				if (cycleActive) begin
					if (cpuReq.weL) begin
						nextState = cachePkg::checkHit;
					end else begin
						wr.valid   = 1'b0;            // drop a stale copy
						wr.validWe = result.validHit;
						nextState  = cachePkg::writeThrough;
					end
				end
			end

			cachePkg::checkHit: begin
				lineRead = 1'b1;
				if (anyHit) begin
					lruTouch = 1'b1;           // hit way becomes most recent
					if (cycleActive) begin
						cpuResp.dtackL = 1'b0;
						nextState      = cachePkg::waitCacheRead;
					end else begin
						nextState = cachePkg::idle;
					end
				end else begin
					dramCmd.selectL = 1'b0;    // start the dram read now
					loadFill        = 1'b1;
					nextState       = cachePkg::allocLine;
				end
			end

			cachePkg::waitCacheRead: begin
				lineRead = 1'b1;
				if (cycleActive)
					cpuResp.dtackL = 1'b0;
				else
					nextState = cachePkg::idle;
			end

			cachePkg::allocLine: begin
				lineRead        = 1'b1;
				dramCmd.selectL = 1'b0;
				wr.valid        = 1'b1;
				wr.tagWe        = fillMask;
				wr.validWe      = fillMask;
				lruTouch        = 1'b1;
				lruTouchWay     = fillWay;
				if (!dramStat.casL && dramStat.rasL) begin   // read cas, not a refresh
					cntNext   = '0;
					nextState = cachePkg::casWait;
				end
			end

			cachePkg::casWait: begin
				lineRead        = 1'b1;
				dramCmd.selectL = 1'b0;
				if (cnt == cachePkg::setIdx_t'(`CAS_LATENCY-1)) begin
					cntNext   = '0;
					nextState = cachePkg::burstFill;
				end else begin
					cntNext = cnt + 1'b1;
				end
			end

			cachePkg::burstFill: begin
				lineRead        = 1'b1;
				dramCmd.selectL = 1'b0;
				lookupWord      = cachePkg::wordIdx_t'(cnt);   // word 0 first
				wr.dataWe       = fillMask;
				cntNext         = cnt + 1'b1;
				if (cnt == cachePkg::setIdx_t'(`LINE_WORDS-1)) begin
					cntNext   = '0;
					nextState = cachePkg::endFill;
				end
			end

			cachePkg::endFill: begin      // line complete, answer from the cache
				lineRead = 1'b1;
				if (cycleActive)
					cpuResp.dtackL = 1'b0;
				else
					nextState = cachePkg::idle;
			end

			cachePkg::writeThrough: begin
				dramCmd.selectL = 1'b0;
				if (cycleActive)
					cpuResp.dtackL = dramStat.dtackL;   // dram paces the cpu
				else
					nextState = cachePkg::idle;
			end

			default: nextState = cachePkg::resetClr;
		endcase

		// fills always fetch the whole line, both bytes
		if (lineRead) begin
			dramCmd.address[3:0] = 4'b0000;
			dramCmd.udsL         = 1'b0;
			dramCmd.ldsL         = 1'b0;
		end

		wr.set  = lookupSet;
		wr.word = lookupWord;
	end

endmodule

// File: m68kCacheTop.sv
// 68k read cache top level
`timescale 1ns/1ps
`include "m68k_cache_config.svh"

module m68kCacheTop (
	input  logic                  Clock,
	input  logic                  Reset_L,
	input  cpuBusPkg::cpuReq_t    cpuReq,
	input  cpuBusPkg::dramStat_t  dramStat,
	output cpuBusPkg::cpuResp_t   cpuResp,
	output cpuBusPkg::dramCmd_t   dramCmd
);

	cachePkg::storeWr_t  wr;            // controller writes into the store
	cachePkg::lookup_t   result;
	cachePkg::setIdx_t   lookupSet;     // shared by store and lru
	cachePkg::wordIdx_t  lookupWord;
	cachePkg::tag_t      lookupTag;
	cachePkg::wayIdx_t   victim;
	cachePkg::wayIdx_t   lruTouchWay;
	logic                lruClear;
	logic                lruTouch;

	assign lookupTag = cpuReq.address[`ADDR_W-1 -: `TAG_W];   // bits 31..11

	cacheStore u_cacheStore (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.wr         (wr),
		.fillData   (dramStat.readData),   // burst words go straight in
		.lookupSet  (lookupSet),
		.lookupTag  (lookupTag),
		.lookupWord (lookupWord),
		.result     (result)
	);

	lruPolicy u_lruPolicy (
		.Clock    (Clock),
		.Reset_L  (Reset_L),
		.set      (lookupSet),
		.clear    (lruClear),
		.touch    (lruTouch),
		.touchWay (lruTouchWay),
		.victim   (victim)
	);

	cacheController u_cacheController (
		.Clock       (Clock),
		.Reset_L     (Reset_L),
		.cpuReq      (cpuReq),
		.dramStat    (dramStat),
		.result      (result),
		.victim      (victim),
		.cpuResp     (cpuResp),
		.dramCmd     (dramCmd),
		.wr          (wr),
		.lookupSet   (lookupSet),
		.lookupWord  (lookupWord),
		.lruClear    (lruClear),
		.lruTouch    (lruTouch),
		.lruTouchWay (lruTouchWay)
	);

endmodule

// File: m68kCacheTop_sva.sv
// cache bus assertions
`timescale 1ns/1ps

module m68kCacheTop_sva (
	input logic                   Clock,
	input logic                   Reset_L,
	input cpuBusPkg::cpuReq_t     cpuReq,
	input cpuBusPkg::cpuResp_t    cpuResp,
	input cpuBusPkg::dramCmd_t    dramCmd,
	input cachePkg::wayMask_t     dataWe,     // data write masks of the store
	input cachePkg::cacheState_e  state       // controller state
);

	// dtack only inside a bus cycle
	dtackInCycle: assert property (@(posedge Clock) disable iff (!Reset_L)
		cpuReq.asL |-> cpuResp.dtackL)
		else $error("DTACK low while the address strobe is high");

	// a burst word goes to one way only
	oneDataWay: assert property (@(posedge Clock) disable iff (!Reset_L)
		$onehot0(dataWe))
		else $error("more than one way written with fill data");

	// no dram access from idle
	idleNoSelect: assert property (@(posedge Clock) disable iff (!Reset_L)
		(state == cachePkg::idle) |-> dramCmd.selectL)
		else $error("DRAM select low while the controller is idle");

endmodule

bind m68kCacheTop m68kCacheTop_sva u_m68kCacheTop_sva (
	.Clock   (Clock),
	.Reset_L (Reset_L),
	.cpuReq  (cpuReq),
	.cpuResp (cpuResp),
	.dramCmd (dramCmd),
	.dataWe  (wr.dataWe),
	.state   (u_cacheController.state)
);

// File: m68kCacheTop_tb.sv
// m68k read cache testbench
`timescale 1ns/1ps
`include "m68k_cache_config.svh"

module m68kCacheTop_tb;

	// ~132 clocks of reset walk plus ~30 bus cycles of up to ~25 clocks with about 3x margin
	localparam int TimeoutCycles = 3000;

	logic                  Clock = 1'b0;
	logic                  Reset_L;
	cpuBusPkg::cpuReq_t    cpuReq;
	cpuBusPkg::cpuResp_t   cpuResp;
	cpuBusPkg::dramCmd_t   dramCmd;
	cpuBusPkg::dramStat_t  dramStat;

	int           errors  = 0;
	int           testsOk = 0;
	int           testsBad = 0;
	int           cycles  = 0;
	logic [31:0]  rngState = 32'hdda5;

	logic [15:0]  dramMem [logic [30:0]];  // written words by word address
	logic [31:0]  lastRdAddr;              // line address of the last dram read
	logic [2:0]   lastRdStrobes;           // as uds lds seen on it
	logic [31:0]  lastWrAddr;
	logic [15:0]  lastWrData;

	logic [20:0]  modelTag [4];            // reference contents of the test set
	bit           modelValid [4];
	logic [2:0]   modelTree;               // b2 b1 b0

	m68kCacheTop u_m68kCacheTop (
		.Clock    (Clock),
		.Reset_L  (Reset_L),
		.cpuReq   (cpuReq),
		.dramStat (dramStat),
		.cpuResp  (cpuResp),
		.dramCmd  (dramCmd)
	);

	always #50 Clock = ~Clock;   // 100 ns period

	// watchdog
	always @(posedge Clock) begin
		cycles++;
		if (cycles >= TimeoutCycles) begin
			$display("timeout: run did not finish within %0d clock cycles", TimeoutCycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// dram content where written words override the pattern
	function automatic logic [15:0] memWord(input logic [30:0] wordAddr);
		logic [31:0] mix;
		if (dramMem.exists(wordAddr))
			return dramMem[wordAddr];
		mix = xorshift(32'hdda5 ^ {1'b0, wordAddr});
		return mix[15:0];
	endfunction

	task automatic flagMismatch(input string msg, input logic [31:0] got, input logic [31:0] exp);
		$display("Fail at %0t: %s, got %h expected %h", $time, msg, got, exp);
		errors++;
	endtask

	task automatic flagProblem(input string msg);
		$display("error at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic endTest(input string name, input int errsBefore);
		if (errors == errsBefore) begin
			testsOk++;
			$display("test %s: ok", name);
		end else begin
			testsBad++;
			$display("test %s: %0d errors", name, errors - errsBefore);
		end
	endtask

	// pseudo lru reference for one set that reports a miss
	task automatic modelAccess(input logic [20:0] tag, output bit miss);
		int way;
		way = -1;
		for (int w = 3; w >= 0; w--)
			if (modelValid[w] && modelTag[w] == tag)
				way = w;
		miss = (way < 0);
		if (miss) begin
			for (int w = 3; w >= 0; w--)
				if (!modelValid[w])
					way = w;                       // empty ways first
			if (way < 0)
				way = modelTree[0] ? (modelTree[2] ? 3 : 2) : (modelTree[1] ? 1 : 0);
			modelTag[way]   = tag;
			modelValid[way] = 1'b1;
		end
		case (way)
			0:       modelTree = {modelTree[2], 2'b11};
			1:       modelTree = {modelTree[2], 2'b01};
			2:       modelTree = {1'b1, modelTree[1], 1'b0};
			default: modelTree = {1'b0, modelTree[1], 1'b0};
		endcase
	endtask

	// one cpu read with the given uds lds strobes
	// selFall is the clock on which the select first fell, or 0 if it never did
	task automatic cpuRead(input logic [31:0] addr, input logic [1:0] strobes,
		output logic [15:0] data, output int selFall);
		int n;
		n = 0;
		selFall = 0;
		@(posedge Clock);
		#1;
		cpuReq.address    = addr;
		cpuReq.weL        = 1'b1;
		cpuReq.udsL       = strobes[1];
		cpuReq.ldsL       = strobes[0];
		cpuReq.asL        = 1'b0;
		cpuReq.dramSelect = 1'b1;
		do begin
			@(negedge Clock);             // mid cycle with outputs settled
			n++;
			if (!dramCmd.selectL && selFall == 0)
				selFall = n;
		end while (cpuResp.dtackL);
		data = cpuResp.readData;
		@(posedge Clock);
		#1;
		cpuReq.asL        = 1'b1;
		cpuReq.dramSelect = 1'b0;
	endtask

	task automatic cpuWrite(input logic [31:0] addr, input logic [15:0] value);
		@(posedge Clock);
		#1;
		cpuReq.address    = addr;
		cpuReq.writeData  = value;
		cpuReq.weL        = 1'b0;
		cpuReq.udsL       = 1'b0;
		cpuReq.ldsL       = 1'b0;
		cpuReq.asL        = 1'b0;
		cpuReq.dramSelect = 1'b1;
		do begin
			@(negedge Clock);
			assert (dramCmd.selectL || cpuResp.dtackL == dramStat.dtackL)
				else flagMismatch("cpu DTACK vs dram DTACK", cpuResp.dtackL, dramStat.dtackL);
		end while (cpuResp.dtackL);
		@(posedge Clock);
		#1;
		cpuReq.asL        = 1'b1;
		cpuReq.dramSelect = 1'b0;
		cpuReq.weL        = 1'b1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// dram controller model
	//////////////////////////////////////////////////////////////////////

	initial begin : dramModel
		int          rdCnt;
		int          wrCnt;
		int          k;
		logic [30:0] wa;
		logic [15:0] word;
		rdCnt    = 0;
		wrCnt    = 0;
		dramStat = '{readData: '0, casL: 1'b1, rasL: 1'b1, dtackL: 1'b1};
		forever begin
			@(posedge Clock);                 // pins as they were before the edge
			rdCnt = (!dramCmd.selectL && dramCmd.weL) ? rdCnt + 1 : 0;
			wrCnt = (!dramCmd.selectL && !dramCmd.weL) ? wrCnt + 1 : 0;
			if (rdCnt == 1) begin
				lastRdAddr    = dramCmd.address;
				lastRdStrobes = {dramCmd.asL, dramCmd.udsL, dramCmd.ldsL};
			end
			if (wrCnt == 2) begin            // write lands with dtack
				wa   = dramCmd.address[31:1];
				word = memWord(wa);
				if (!dramCmd.udsL)
					word[15:8] = dramCmd.writeData[15:8];
				if (!dramCmd.ldsL)
					word[7:0] = dramCmd.writeData[7:0];
				dramMem[wa] = word;
				lastWrAddr  = dramCmd.address;
				lastWrData  = dramCmd.writeData;
			end
			#1;
			dramStat.casL   = !(rdCnt == 3);  // read cas with ras high
			dramStat.rasL   = 1'b1;
			dramStat.dtackL = !(wrCnt >= 2);
			k = rdCnt - (4 + `CAS_LATENCY);    // burst word index so word 0 lands cas_latency+1 after cas
			if (k >= 0 && k < `LINE_WORDS)
				dramStat.readData = memWord(lastRdAddr[31:1] + 31'(k));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		logic [15:0] got;
		logic [15:0] value;
		logic [31:0] addr;
		logic [31:0] base;
		logic [20:0] tag;
		int          selFall;
		int          errs;
		int          pick;
		bit          miss;
		Reset_L = 1'b0;
		cpuReq  = '{address: '0, writeData: '0, udsL: 1'b1, ldsL: 1'b1, weL: 1'b1,
			asL: 1'b1, dramSelect: 1'b0};
		for (int w = 0; w < 4; w++)
			modelValid[w] = 1'b0;
		modelTree = '0;

		// 1 reset where a request during invalidation waits and then misses
		errs = errors;
		@(negedge Clock);
		assert (cpuResp.dtackL && dramCmd.selectL)
			else flagProblem("DTACK or DRAM select low during reset");
		repeat (2) @(posedge Clock);
		#1;
		Reset_L = 1'b1;
		addr = 32'h0000_1002;
		cpuRead(addr, 2'b00, got, selFall);
		assert (selFall > `CACHE_SETS)
			else flagProblem("DRAM select fell before invalidation ended, or never");
		assert (got == memWord(addr[31:1]))
			else flagMismatch("first read", got, memWord(addr[31:1]));
		endTest("1 reset and first miss", errs);

		// 2 miss fetches the aligned line
		errs = errors;
		base = 32'h0004_2A26;
		cpuRead(base, 2'b10, got, selFall);   // lower byte read while the fill takes both
		assert (selFall != 0) else flagProblem("read miss did not select DRAM");
		assert (lastRdAddr == {base[31:4], 4'h0})
			else flagMismatch("dram read address", lastRdAddr, {base[31:4], 4'h0});
		assert (lastRdStrobes == 3'b000)
			else flagProblem("fill read without the address strobe and both data strobes");
		assert (got == memWord(base[31:1]))
			else flagMismatch("miss data", got, memWord(base[31:1]));
		endTest("2 read miss", errs);

		// 3 rest of the line hits
		errs = errors;
		for (int w = 0; w < `LINE_WORDS; w++) begin
			addr = {base[31:4], 3'(w), 1'b0};
			cpuRead(addr, 2'b00, got, selFall);
			assert (selFall == 0) else flagProblem("hit in a filled line selected DRAM");
			assert (got == memWord(addr[31:1]))
				else flagMismatch("hit data", got, memWord(addr[31:1]));
		end
		endTest("3 read hits", errs);

		// 4 write through and then the line misses again
		errs = errors;
		rngState = xorshift(rngState);
		value    = rngState[15:0];
		cpuWrite(base, value);
		assert (lastWrAddr == base) else flagMismatch("dram write address", lastWrAddr, base);
		assert (lastWrData == value) else flagMismatch("dram write data", lastWrData, value);
		cpuRead(base, 2'b00, got, selFall);
		assert (selFall != 0) else flagProblem("read after write hit a stale line");
		assert (got == value) else flagMismatch("read after write", got, value);
		endTest("4 write through", errs);

		// 5 five tags in set 0x55 checked against the tree model
		errs = errors;
		for (int i = 0; i < 16; i++) begin
			rngState = xorshift(rngState);
			if (i < 4)
				pick = i;                    // fill ways 0..3
			else if (i == 4)
				pick = 0;
			else if (i == 5)
				pick = 4;                    // first eviction
			else
				pick = int'(rngState % 32'd5);
			tag  = 21'(32'h100 + pick);
			addr = {tag, 7'h55, rngState[10:8], 1'b0};
			modelAccess(tag, miss);
			cpuRead(addr, 2'b00, got, selFall);
			assert ((selFall != 0) == miss)
				else flagProblem($sformatf("tag %h hit or miss differs from the LRU model", tag));
			assert (got == memWord(addr[31:1]))
				else flagMismatch("set data", got, memWord(addr[31:1]));
		end
		endTest("5 pseudo lru eviction", errs);

		$display("tests ok %0d, tests with errors %0d, failed checks %0d", testsOk, testsBad, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: m68kCacheTop.f
+incdir+.
cpuBusPkg.sv
cachePkg.sv
cacheStore.sv
lruPolicy.sv
cacheController.sv
m68kCacheTop.sv
m68kCacheTop_sva.sv
m68kCacheTop_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the m68k cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f m68kCacheTop.f \
	--top-module m68kCacheTop_tb \
	-Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vm68kCacheTop_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^SIMULATION PASSED$"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
